// ==== Bender.yml ====
package:
  name: rx_decim

sources:
  - rtl/cic_pkg.sv
  - rtl/rx_stream_pkg.sv
  - rtl/cic_strobe_gen.sv
  - rtl/cic_dec_shifter.sv
  - rtl/cic_decim.sv
  - rtl/rx_decim_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_rx_decim.sv

// ==== build.f ====
rtl/cic_pkg.sv
rtl/rx_stream_pkg.sv
rtl/cic_strobe_gen.sv
rtl/cic_dec_shifter.sv
rtl/cic_decim.sv
rtl/rx_decim_top.sv
dv/tb_clock_gen.sv
dv/tb_rx_decim.sv

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source with a 10 ns clock and a reset held for four cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
   output logic clock,
   output logic reset
);
   localparam int half_period  = 5;
   localparam int reset_cycles = 4;

   // free running clock whose first rising edge comes at 5 ns
   initial
   begin
      clock = 1'b0;
      forever #half_period clock = ~clock;
   end

   // reset drops a little after an edge so the DUT never sees it change on the edge
   initial
   begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clock);
      #1;
      reset = 1'b0;
   end

endmodule
`default_nettype wire

// ==== dv/tb_rx_decim.sv ====
// Table driven testbench for the CIC decimation top, checking DC gain and output counts
`timescale 1ns/1ns
`default_nettype none

module tb_rx_decim;
   import cic_pkg::*;
   import rx_stream_pkg::*;

   localparam int drive_delay  = 1;
   localparam int drain_cycles = 3;
   localparam int idle_cycles  = 10;
   localparam int limit_margin = 200;

   // one test step whose expected values are filled in from the gain rule
   typedef struct packed {
      logic                           enable;
      logic [rate_width-1:0]          rate;
      logic                           random_mode;
      logic signed [sample_width-1:0] value;
      int                             spacing;
      int                             samples;
      int                             settle;
      logic signed [sample_width-1:0] expected;
      int                             expected_count;
   } test_row_t;

   logic        clock;
   logic        reset;
   decim_ctrl_t ctrl;
   sample_t     in_sample;
   sample_t     out_sample;

   test_row_t   test_rows [$];
   test_row_t   cur_row;
   int          row_count;
   logic        last_valid;
   logic [31:0] lcg_state = 32'hb891_0827;
   int          cycle_count;
   int          cycle_limit;

   tb_clock_gen u_clock_gen (
      .clock (clock),
      .reset (reset)
   );

   rx_decim_top u_dut (
      .clock      (clock),
      .reset      (reset),
      .ctrl       (ctrl),
      .in_sample  (in_sample),
      .out_sample (out_sample)
   );

   // stops at the first wrong value
   task automatic check_equal(input longint actual, input longint expected, input string what);
      if (actual != expected)
      begin
         $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
         $display("Simulation failed");
         $fatal(1, "first error ends the run");
      end
   endtask

   // 32 bit linear congruential step whose upper half gives the sample
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // DC gain is rate**4, scaled down by 2**(4*ceil(log2(rate))) with flooring
   function automatic logic signed [sample_width-1:0] expected_dc(input int x, input int rate);
      longint gain;
      longint product;
      int     clog;
      clog = 0;
      while ((1 << clog) < rate)
         clog++;
      gain    = longint'(rate) * rate * rate * rate;
      product = longint'(x) * gain;
      return sample_width'(product >>> (num_stages * clog));
   endfunction

   task automatic add_test_row(input logic en, input int rate, input logic rnd, input int value,
                               input int spacing, input int samples, input int settle);
      test_row_t row;
      row.enable         = en;
      row.rate           = rate_width'(rate);
      row.random_mode    = rnd;
      row.value          = sample_width'(value);
      row.spacing        = spacing;
      row.samples        = samples;
      row.settle         = settle;
      row.expected       = expected_dc(value, rate);
      // a disabled row must not produce anything
      row.expected_count = en ? samples / rate : 0;
      test_rows.push_back(row);
   endtask

   // entered just after a rising edge and left just after one
   task automatic apply_row(input test_row_t row, input int idx);
      // one disabled cycle lets the rate change and restarts the decimation phase
      ctrl.enable     = 1'b0;
      ctrl.rate       = row.rate;
      in_sample.valid = 1'b0;
      cur_row         = row;
      row_count       = 0;
      @(posedge clock);
      #drive_delay;
      ctrl.enable = row.enable;
      for (int i = 0; i < row.samples; i++)
      begin
         if (row.random_mode)
         begin
            lcg_state      = lcg_next(lcg_state);
            in_sample.data = lcg_state[31:16];
         end
         else
            in_sample.data = row.value;
         in_sample.valid = 1'b1;
         @(posedge clock);
         #drive_delay;
         in_sample.valid = 1'b0;
         for (int s = 1; s < row.spacing; s++)
         begin
            @(posedge clock);
            #drive_delay;
         end
      end
      // valid trails strobe_out by one cycle, so a short drain catches the last output
      repeat (drain_cycles)
      begin
         @(posedge clock);
         #drive_delay;
      end
      check_equal(row_count, row.expected_count, $sformatf("output count of row %0d", idx));
   endtask

   // outputs are read mid cycle where they are stable
   always @(negedge clock)
   begin
      if (!reset)
      begin
         if (!ctrl.enable)
            check_equal(out_sample.valid, 0, "valid output while enable is low");
         // back to back valids only happen at rate 1 with a strobe every cycle
         if (out_sample.valid && !(cur_row.rate == 1 && cur_row.spacing == 1))
            check_equal(last_valid, 0, "valid held high for more than one cycle");
         if (out_sample.valid)
         begin
            if (!cur_row.random_mode && row_count >= cur_row.settle)
               check_equal($signed(out_sample.data), $signed(cur_row.expected),
                           $sformatf("output %0d at rate %0d", row_count, cur_row.rate));
            row_count++;
         end
         last_valid = out_sample.valid;
      end
   end

   always @(posedge clock)
   begin
      cycle_count++;
      if (cycle_count > cycle_limit)
      begin
         $display("Timeout: the run went past %0d clock cycles without finishing", cycle_limit);
         $display("Simulation failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   initial
   begin
      int limit_sum;
      ctrl        = '{enable: 1'b0, rate: rate_width'(1)};
      in_sample   = '0;
      cur_row     = '0;
      row_count   = 0;
      last_valid  = 1'b0;
      cycle_count = 0;

      // columns are enable, rate, random, value, spacing, samples, outputs skipped before checks
      // unity gain at power of two rates with positive, negative and full scale values
      add_test_row(1'b1, 1, 1'b0, 1000, 1, 40, 16);
      add_test_row(1'b1, 2, 1'b0, -1234, 1, 48, 16);
      add_test_row(1'b1, 8, 1'b0, 32767, 1, 192, 16);
      add_test_row(1'b1, 128, 1'b0, -32768, 1, 2560, 16);
      add_test_row(1'b1, 128, 1'b0, 32767, 1, 2560, 16);
      // other rates come out below unity by the floor rule
      add_test_row(1'b1, 3, 1'b0, 2000, 1, 72, 16);
      add_test_row(1'b1, 5, 1'b0, -777, 1, 120, 16);
      add_test_row(1'b1, 100, 1'b0, 12345, 1, 2000, 16);
      // output counts with sample totals that are not a multiple of the rate
      add_test_row(1'b1, 7, 1'b1, 0, 1, 100, 0);
      add_test_row(1'b1, 7, 1'b1, 0, 3, 100, 0);
      add_test_row(1'b1, 1, 1'b1, 0, 3, 25, 0);
      // a pause ends on a phase boundary, so the DC value must hold from the first output
      add_test_row(1'b1, 4, 1'b0, 5000, 1, 96, 16);
      add_test_row(1'b0, 4, 1'b0, 5000, 1, 40, 0);
      add_test_row(1'b1, 4, 1'b0, 5000, 3, 40, 0);
      add_test_row(1'b0, 4, 1'b1, 0, 2, 30, 0);
      add_test_row(1'b1, 4, 1'b0, 5000, 1, 40, 0);
      // random stream broken by a pause
      add_test_row(1'b1, 6, 1'b1, 0, 2, 50, 0);
      add_test_row(1'b0, 6, 1'b1, 0, 1, 20, 0);
      add_test_row(1'b1, 6, 1'b1, 0, 1, 37, 0);

      // each row costs its strobes plus the disabled cycle, the drain and one spare cycle
      limit_sum = 0;
      foreach (test_rows[r])
         limit_sum += test_rows[r].samples * test_rows[r].spacing + drain_cycles + 2;
      cycle_limit = limit_sum + idle_cycles + 4 + limit_margin;

      @(negedge reset);
      repeat (idle_cycles)
      begin
         @(posedge clock);
         #drive_delay;
      end
      check_equal(row_count, 0, "valid outputs before any input");

      foreach (test_rows[r])
         apply_row(test_rows[r], r);

      $display("Simulation passed");
      $finish;
   end

endmodule
`default_nettype wire

// ==== rtl/cic_dec_shifter.sv ====
// CIC gain shifter that takes the output window of the wide comb result set by the rate
`timescale 1ns/1ns
`default_nettype none

module cic_dec_shifter (
   input  logic [rx_stream_pkg::rate_width-1:0]    rate,
   input  cic_pkg::acc_t                           signal_in,
   output logic signed [cic_pkg::sample_width-1:0] signal_out
);
   import cic_pkg::*;
   import rx_stream_pkg::*;

   logic [rate_width-1:0]  rate_m1;
   logic [log2_width-1:0]  ceil_log2;
   logic [shift_width-1:0] shift;

   // ceil(log2(rate)) equals the bit length of rate minus 1
   assign rate_m1 = rate - rate_width'(1);

   // priority encoder on the highest set bit of rate minus 1
   always_comb
   begin
      ceil_log2 = '0;
      // later iterations win, so the highest set bit decides
      for (int b = 0; b < log2_max_rate; b++)
      begin
         if (rate_m1[b])
            ceil_log2 = log2_width'(b + 1);
      end
      // rate 0 or anything above max_rate saturates at the widest window
      if (rate_m1[rate_width-1:log2_max_rate] != '0)
         ceil_log2 = log2_width'(log2_max_rate);
   end

   // the filter gain is rate**num_stages, so the shift is num_stages bits
   // for every doubling of the rate
   assign shift = shift_width'(ceil_log2 * num_stages);

   // the window drops the low bits, which truncates toward minus infinity
   // just like an arithmetic right shift
   // a power of two rate gives unity gain, other rates come out a bit low
   // the top bit of the widest window is the top bit of the accumulator
   assign signal_out = $signed(signal_in[shift +: sample_width]);

endmodule
`default_nettype wire

// ==== rtl/cic_decim.sv ====
// CIC decimator with four wrapping integrators, sampler, four pipelined combs and gain shift
`timescale 1ns/1ns
`default_nettype none

module cic_decim (
   input  logic                                    clock,
   input  logic                                    reset,
   input  rx_stream_pkg::decim_ctrl_t              ctrl,
   input  logic                                    strobe_in,
   input  logic                                    strobe_out,
   input  logic signed [cic_pkg::sample_width-1:0] signal_in,
   output logic signed [cic_pkg::sample_width-1:0] signal_out
);
   import cic_pkg::*;

   acc_t signal_in_ext;
   acc_t integrator [num_stages];
   acc_t sampler;
   acc_t differentiator [num_stages];
   acc_t pipeline [num_stages];
   logic signed [sample_width-1:0] shifted;

   // sign extension to the full accumulator width
   assign signal_in_ext = acc_t'(signal_in);

   // integrator section at the input rate
   // the sums wrap freely and the combs undo the wrap, since the final
   // result always fits in acc_width bits
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < num_stages; i++)
            integrator[i] <= '0;
      end
      else if (ctrl.enable && strobe_in)
      begin
         integrator[0] <= integrator[0] + signal_in_ext;
         // each stage adds the old value of the stage before it
         for (int i = 1; i < num_stages; i++)
            integrator[i] <= integrator[i] + integrator[i-1];
      end
   end

   // comb section at the decimated rate
   // the sampler grabs the last integrator, then every comb stage keeps
   // its previous input and passes on the difference, one stage per strobe
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         sampler <= '0;
         for (int i = 0; i < num_stages; i++)
         begin
            differentiator[i] <= '0;
            pipeline[i]       <= '0;
         end
      end
      else if (ctrl.enable && strobe_out)
      begin
         sampler           <= integrator[num_stages-1];
         differentiator[0] <= sampler;
         pipeline[0]       <= sampler - differentiator[0];
         for (int i = 1; i < num_stages; i++)
         begin
            differentiator[i] <= pipeline[i-1];
            pipeline[i]       <= pipeline[i-1] - differentiator[i];
         end
      end
   end

   // removes the rate dependent gain by picking a window of the comb result
   cic_dec_shifter u_shifter (
      .rate       (ctrl.rate),
      .signal_in  (pipeline[num_stages-1]),
      .signal_out (shifted)
   );

   // the output register adds one cycle that the top matches on its valid bit
   always_ff @(posedge clock)
   begin
      signal_out <= shifted;
   end

   // the top masks the input strobe with enable and the strobe generator
   // gates its own output, so neither strobe may show up while disabled
   strobe_enable_a : assert property (@(posedge clock) disable iff (reset)
      (strobe_in || strobe_out) |-> ctrl.enable);

   // the decimated strobe is always one of the input strobes
   strobe_pair_a : assert property (@(posedge clock) disable iff (reset)
      strobe_out |-> strobe_in);

endmodule
`default_nettype wire

// ==== rtl/cic_pkg.sv ====
// CIC filter arithmetic package with the stage count, rate limits and wide accumulator word
`default_nettype none

package cic_pkg;

   // real samples enter and leave the filter at this width
   localparam int sample_width = 16;

   // four integrators followed by four combs
   localparam int num_stages = 4;

   // the rate is limited to 2**7 = 128
   localparam int log2_max_rate = 7;
   localparam int max_rate = 1 << log2_max_rate;

   // worst case filter gain is max_rate**num_stages, expressed in bits
   localparam int max_bit_gain = num_stages * log2_max_rate;

   // accumulators carry the full gain so the integrators may wrap safely
   localparam int acc_width = sample_width + max_bit_gain;

   // width of the ceil(log2(rate)) result that runs from 0 up to log2_max_rate
   localparam int log2_width = $clog2(log2_max_rate + 1);

   // width of the output window offset that runs from 0 up to max_bit_gain
   localparam int shift_width = $clog2(max_bit_gain + 1);

   // signed word used by every integrator, comb and the shifter input
   typedef logic signed [acc_width-1:0] acc_t;

endpackage
`default_nettype wire

// ==== rtl/cic_strobe_gen.sv ====
// CIC strobe generator that counts input strobes and fires one output strobe per rate inputs
`timescale 1ns/1ns
`default_nettype none

module cic_strobe_gen (
   input  logic                       clock,
   input  logic                       reset,
   input  rx_stream_pkg::decim_ctrl_t ctrl,
   input  logic                       strobe_in,
   output logic                       strobe_out
);
   import cic_pkg::*;
   import rx_stream_pkg::*;

   logic [rate_width-1:0]    rate_m1;
   logic [log2_max_rate-1:0] reload;
   logic [log2_max_rate-1:0] count;

   // rate 128 gives 127 which still fits the 7 bit counter
   assign rate_m1 = ctrl.rate - rate_width'(1);
   assign reload  = rate_m1[log2_max_rate-1:0];

   // the counter sits at rate minus 1 while disabled, so the decimation
   // phase always starts from the first strobe after enable rises
   always_ff @(posedge clock)
   begin
      if (reset || !ctrl.enable)
      begin
         count <= reload;
      end
      else if (strobe_in)
      begin
         // wrap back to the reload value on the strobe that finds zero
         if (count == '0)
            count <= reload;
         else
            count <= count - 1'b1;
      end
   end

   // fires together with the input strobe that lands on zero, so rate 1
   // passes every input strobe straight through
   assign strobe_out = ctrl.enable && strobe_in && (count == '0);

   // the counter and the shifter only cover rates 1 to max_rate
   rate_legal_a : assert property (@(posedge clock) disable iff (reset)
      ctrl.enable |-> (ctrl.rate >= 1) && (ctrl.rate <= max_rate));

   // a rate change while running would break the phase and the gain shift
   rate_stable_a : assert property (@(posedge clock) disable iff (reset)
      ctrl.enable && $past(ctrl.enable) |-> $stable(ctrl.rate));

endmodule
`default_nettype wire

// ==== rtl/rx_decim_top.sv ====
// Receive decimation top that joins the strobe generator and the CIC decimator on one stream
`timescale 1ns/1ns
`default_nettype none

module rx_decim_top (
   input  logic                       clock,
   input  logic                       reset,
   input  rx_stream_pkg::decim_ctrl_t ctrl,
   input  rx_stream_pkg::sample_t     in_sample,
   output rx_stream_pkg::sample_t     out_sample
);
   import cic_pkg::*;

   logic                           strobe_in;
   logic                           strobe_out;
   logic                           valid_q;
   logic signed [sample_width-1:0] decim_data;

   // samples that arrive while disabled are ignored by the whole chain
   assign strobe_in = in_sample.valid && ctrl.enable;

   cic_strobe_gen u_strobe_gen (
      .clock      (clock),
      .reset      (reset),
      .ctrl       (ctrl),
      .strobe_in  (strobe_in),
      .strobe_out (strobe_out)
   );

   cic_decim u_decim (
      .clock      (clock),
      .reset      (reset),
      .ctrl       (ctrl),
      .strobe_in  (strobe_in),
      .strobe_out (strobe_out),
      .signal_in  (in_sample.data),
      .signal_out (decim_data)
   );

   // one cycle of delay matches the decimator output register
   always_ff @(posedge clock)
   begin
      if (reset)
         valid_q <= 1'b0;
      else
         valid_q <= strobe_out;
   end

   assign out_sample = '{valid: valid_q, data: decim_data};

endmodule
`default_nettype wire

// ==== rtl/rx_stream_pkg.sv ====
// Receive stream package with the strobed sample word and the decimation control word
`default_nettype none

package rx_stream_pkg;

   // the rate field holds 1 to 128, so one extra bit above log2 of the maximum
   localparam int rate_width = 8;

   // one sample on the stream whose valid bit is a single cycle strobe
   typedef struct packed {
      logic                                   valid;
      logic signed [cic_pkg::sample_width-1:0] data;
   } sample_t;

   // decimation control whose rate only changes while enable is low
   typedef struct packed {
      logic                  enable;
      logic [rate_width-1:0] rate;
   } decim_ctrl_t;

endpackage
`default_nettype wire
